// ==== dv/sdCardModel.sv ====
`timescale 1ns/100ps

/*
  SPI mode-0 SD card stand-in. Shifts mosi in on the sclk rise and answers
  each byte with the complement of the byte before it.
*/

module sdCardModel (
  input  logic       sclk,
  input  logic       mosi,
  input  logic       ssN,
  output logic       miso,
  output logic [7:0] rxByte,
  output int         byteCount
);

  logic [7:0] inShift;
  logic [7:0] outShift;
  int         bitCount;

  // first answer bit is waiting on the line before any clock
  initial
  begin
    inShift   = '0;
    outShift  = sdSpiPkg::cardIdleByte;
    miso      = sdSpiPkg::cardIdleByte[7];
    rxByte    = '0;
    byteCount = 0;
    bitCount  = 0;
  end

  always @(posedge sclk)
  begin
    if (!ssN)
    begin
      inShift  <= {inShift[6:0], mosi};
      bitCount <= bitCount + 1;
      if (bitCount == 7)
      begin
        rxByte    <= {inShift[6:0], mosi};
        byteCount <= byteCount + 1;
        bitCount  <= 0;
      end
    end
  end

  // next answer bit goes out on the falling edge
  always @(negedge sclk)
  begin
    if (!ssN)
    begin
      if (bitCount == 0)
      begin
        outShift <= ~rxByte;
        miso     <= ~rxByte[7];
      end
      else
      begin
        outShift <= {outShift[6:0], 1'b0};
        miso     <= outShift[6];
      end
    end
  end

endmodule

// ==== dv/tbSdSpi.sv ====
`timescale 1ns/100ps

/*
  Testbench for the SD SPI bring-up top. Releases reset, lets the sequencer
  run against the card model and checks pins and received bytes.
*/

module tbSdSpi #(
  parameter int startDelay     = 10,
  parameter bit fastSclk       = 1'b1,
  parameter int fastHalfPeriod = 1,
  parameter int slowHalfPeriod = 4
);

  localparam int         rstCycles   = 16;
  localparam int         watchCycles = (rstCycles + 7 + startDelay
                                        + 2 * 16 * slowHalfPeriod) * 20;
  localparam logic [7:0] expSecond   = ~sdSpiPkg::firstCmd;

  logic       clk;
  logic       rst;
  logic       miso;
  logic       sclk;
  logic       mosi;
  logic       ssN;
  logic       done;
  logic [7:0] rxFirst;
  logic [7:0] rxSecond;
  logic [7:0] cardByte;
  int         cardCount;
  int         lastCount;
  int         cycle;
  int         relCount;
  int         phaseLen;
  int         riseCount;
  logic       lastSclk;
  int         gap;

  sdSpiTop #(
    .startDelay     (startDelay),
    .fastSclk       (fastSclk),
    .fastHalfPeriod (fastHalfPeriod),
    .slowHalfPeriod (slowHalfPeriod)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .miso     (miso),
    .sclk     (sclk),
    .mosi     (mosi),
    .ssN      (ssN),
    .done     (done),
    .rxFirst  (rxFirst),
    .rxSecond (rxSecond)
  );

  sdCardModel card (
    .sclk      (sclk),
    .mosi      (mosi),
    .ssN       (ssN),
    .miso      (miso),
    .rxByte    (cardByte),
    .byteCount (cardCount)
  );

  task automatic abortRun(input string msg);
    begin
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
    end
  endtask

  always #4 clk = ~clk;

  // phase length and edge bookkeeping from sampled pin values
  always @(posedge clk)
  begin
    cycle     <= cycle + 1;
    relCount  <= rst ? 0 : relCount + 1;
    lastSclk  <= sclk;
    lastCount <= cardCount;
    phaseLen  <= (sclk != lastSclk) ? 1 : phaseLen + 1;
    if (sclk && !lastSclk)
      riseCount <= riseCount + 1;
  end

  assert property (@(posedge clk) disable iff (cycle < 2)
    relCount <= startDelay + 1 |-> !sclk && !done && ssN)
    else abortRun("sclk, done or ssN left its reset level before the first access");
  assert property (@(posedge clk) disable iff (cycle < 2) !ssN |=> !ssN)
    else abortRun("ssN went high again after the card was selected");
  assert property (@(posedge clk) disable iff (cycle < 2) sclk != lastSclk |-> !ssN)
    else abortRun("sclk toggled while the card was not selected");

  // low phase before the first bit of a byte is idle time, not a half period
  assert property (@(posedge clk) disable iff (cycle < 2)
    $fell(sclk) |-> phaseLen == fastHalfPeriod)
    else abortRun($sformatf("Mismatch at %0t: sclk high phase = %0d, expected %0d",
                            $time, $sampled(phaseLen), fastHalfPeriod));
  assert property (@(posedge clk) disable iff (cycle < 2)
    $rose(sclk) && riseCount % 8 != 0 |-> phaseLen == fastHalfPeriod)
    else abortRun($sformatf("Mismatch at %0t: sclk low phase = %0d, expected %0d",
                            $time, $sampled(phaseLen), fastHalfPeriod));

  assert property (@(posedge clk) disable iff (cycle < 2)
    cardCount != lastCount |-> cardCount <= 2)
    else abortRun("card model received more than two bytes");
  assert property (@(posedge clk) disable iff (cycle < 2)
    cardCount != lastCount && cardCount == 1 |-> cardByte == sdSpiPkg::firstCmd)
    else abortRun($sformatf("Mismatch at %0t: card byte 1 = %h, expected %h",
                            $time, cardByte, sdSpiPkg::firstCmd));
  assert property (@(posedge clk) disable iff (cycle < 2)
    cardCount != lastCount && cardCount == 2 |-> cardByte == sdSpiPkg::secondCmd)
    else abortRun($sformatf("Mismatch at %0t: card byte 2 = %h, expected %h",
                            $time, cardByte, sdSpiPkg::secondCmd));

  assert property (@(posedge clk) disable iff (cycle < 2)
    $rose(done) |-> rxFirst == sdSpiPkg::cardIdleByte)
    else abortRun($sformatf("Mismatch at %0t: rxFirst = %h, expected %h",
                            $time, rxFirst, sdSpiPkg::cardIdleByte));
  assert property (@(posedge clk) disable iff (cycle < 2)
    $rose(done) |-> rxSecond == expSecond)
    else abortRun($sformatf("Mismatch at %0t: rxSecond = %h, expected %h",
                            $time, rxSecond, expSecond));
  assert property (@(posedge clk) disable iff (cycle < 2) done |=> done)
    else abortRun("done dropped after it had risen");
  assert property (@(posedge clk) disable iff (cycle < 2)
    done |-> !sclk && sclk == lastSclk)
    else abortRun("sclk moved after done rose");

  initial
  begin
    repeat (watchCycles) @(posedge clk);
    abortRun("timeout, done never rose");
  end

  initial
  begin
    clk       = 1'b0;
    rst       = 1'b1;
    cycle     = 0;
    relCount  = 0;
    phaseLen  = 0;
    riseCount = 0;
    lastCount = 0;
    lastSclk  = 1'b0;
    void'($urandom(25));
    gap = $urandom_range(7, 0);
    repeat (rstCycles + gap) @(posedge clk);
    rst <= 1'b0;
    while (!done)
      @(posedge clk);
    // quiet tail so the post-done checks get to run
    repeat (16 * slowHalfPeriod) @(posedge clk);
    assert (cardCount == 2)
      else abortRun($sformatf("Mismatch at %0t: cardCount = %0d, expected 2",
                              $time, cardCount));
    assert (riseCount == 16)
      else abortRun($sformatf("Mismatch at %0t: sclk rising edges = %0d, expected 16",
                              $time, riseCount));
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
# build and run the SD SPI testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --assert -Wno-fatal --top-module tbSdSpi -f sim.f \
  --Mdir obj_dir -o tbSdSpi
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tbSdSpi > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
  echo "simulation exited with status $runStatus"
  exit 1
fi

if grep -q "^PASS: all tests$" "$logFile"; then
  exit 0
else
  echo "pass message not found in $logFile"
  exit 1
fi

// ==== sim.f ====
src/sdSpiPkg.sv
src/regBusIf.sv
src/sdInitSeq.sv
src/spiHost.sv
src/sdSpiTop.sv
dv/sdCardModel.sv
dv/tbSdSpi.sv

// ==== src/regBusIf.sv ====
`timescale 1ns/100ps

/*
  Register bus between the start-up sequencer and the SPI host.
  Strobe is held until a one-cycle acknowledge, read data comes with ack.
*/

interface regBusIf;

  logic        stb;
  logic        we;
  logic        addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        ack;

  modport master (
    output stb, we, addr, wdata,
    input  rdata, ack
  );

  modport slave (
    input  stb, we, addr, wdata,
    output rdata, ack
  );

endinterface

// ==== src/sdInitSeq.sv ====
`timescale 1ns/100ps

/*
  SD SPI start-up sequencer. Runs a fixed program of register accesses on
  the SPI host and keeps the two bytes the card returns.
*/

module sdInitSeq #(
  parameter int startDelay = 10,
  parameter bit fastSclk   = 1'b1
) (
  input  logic       clk,
  input  logic       rst,
  regBusIf.master    bus,
  output logic       done,
  output logic [7:0] rxFirst,
  output logic [7:0] rxSecond
);

  localparam int cntW = $clog2(startDelay + 2);

  typedef enum logic [3:0] {
    sDelay,
    sCtrl,
    sSend1,
    sPoll1,
    sRead1,
    sSend2,
    sPoll2,
    sRead2,
    sHalt
  } stateT;

  stateT            state;
  stateT            nextState;
  logic [cntW-1:0]  count;
  sdSpiPkg::regWord rdWord;
  sdSpiPkg::regWord ctrlWord;

  assign rdWord = bus.rdata;
  assign done   = (state == sHalt);

  always_comb
  begin
    ctrlWord                 = '0;
    ctrlWord.ctrl.selectCard = 1'b1;
    ctrlWord.ctrl.fastClk    = fastSclk;
  end

  // access fields follow the state, which only moves when stb drops
  always_comb
  begin
    bus.we    = 1'b0;
    bus.addr  = sdSpiPkg::ctrlAddr;
    bus.wdata = '0;
    case (state)
      sCtrl:
      begin
        bus.we    = 1'b1;
        bus.wdata = ctrlWord;
      end
      sSend1:
      begin
        bus.we    = 1'b1;
        bus.addr  = sdSpiPkg::dataAddr;
        bus.wdata = {24'h0, sdSpiPkg::firstCmd};
      end
      sSend2:
      begin
        bus.we    = 1'b1;
        bus.addr  = sdSpiPkg::dataAddr;
        bus.wdata = {24'h0, sdSpiPkg::secondCmd};
      end
      sRead1, sRead2:
        bus.addr = sdSpiPkg::dataAddr;
      default:
        bus.addr = sdSpiPkg::ctrlAddr;
    endcase
  end

  // program order, polls repeat until the host reports ready
  always_comb
  begin
    case (state)
      sCtrl:   nextState = sSend1;
      sSend1:  nextState = sPoll1;
      sPoll1:  nextState = rdWord.status.ready ? sRead1 : sPoll1;
      sRead1:  nextState = sSend2;
      sSend2:  nextState = sPoll2;
      sPoll2:  nextState = rdWord.status.ready ? sRead2 : sPoll2;
      sRead2:  nextState = sHalt;
      default: nextState = state;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= sDelay;
      count   <= cntW'(startDelay);
      bus.stb <= 1'b0;
    end
    else if (state == sDelay)
    begin
      // first access goes out as the delay runs out
      if (count == '0)
      begin
        state   <= sCtrl;
        bus.stb <= 1'b1;
      end
      else
        count <= count - 1'b1;
    end
    else if (bus.stb)
    begin
      if (bus.ack)
      begin
        bus.stb <= 1'b0;
        state   <= nextState;
      end
    end
    else if (state != sHalt)
      bus.stb <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (bus.stb && bus.ack && state == sRead1)
      rxFirst <= bus.rdata[7:0];
    if (bus.stb && bus.ack && state == sRead2)
      rxSecond <= bus.rdata[7:0];
  end

  // an access stays on the bus until the host answers
  assert property (@(posedge clk) disable iff (rst) bus.stb && !bus.ack |=> bus.stb);

  // once halted, the sequencer stays halted and off the bus
  assert property (@(posedge clk) disable iff (rst) done |=> done && !bus.stb);

endmodule

// ==== src/sdSpiPkg.sv ====
/*
  SD card SPI link shared definitions: register map, control/status word
  layout and the fixed bytes exchanged with the card.
*/

package sdSpiPkg;

  // one-bit register address on the bus
  localparam logic ctrlAddr = 1'b0;
  localparam logic dataAddr = 1'b1;

  // control view of the word at ctrlAddr, written by the sequencer
  typedef struct packed {
    logic [29:0] reserved;
    logic        fastClk;
    logic        selectCard;
  } ctrlBits;

  // status view of the same word, returned on a read
  typedef struct packed {
    logic [30:0] reserved;
    logic        ready;
  } statusBits;

  typedef union packed {
    ctrlBits   ctrl;
    statusBits status;
  } regWord;

  // bytes sent by the sequencer
  localparam logic [7:0] firstCmd  = 8'hB1;
  localparam logic [7:0] secondCmd = 8'hFF;

  // card answer before it has seen any byte
  localparam logic [7:0] cardIdleByte = 8'hA5;

endpackage

// ==== src/sdSpiTop.sv ====
`timescale 1ns/100ps

/*
  SD card SPI link bring-up top: start-up sequencer driving the SPI host
  over the internal register bus.
*/

module sdSpiTop #(
  parameter int startDelay     = 10,
  parameter bit fastSclk       = 1'b1,
  parameter int fastHalfPeriod = 1,
  parameter int slowHalfPeriod = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       miso,
  output logic       sclk,
  output logic       mosi,
  output logic       ssN,
  output logic       done,
  output logic [7:0] rxFirst,
  output logic [7:0] rxSecond
);

  regBusIf bus ();

  sdInitSeq #(
    .startDelay (startDelay),
    .fastSclk   (fastSclk)
  ) seq (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus.master),
    .done     (done),
    .rxFirst  (rxFirst),
    .rxSecond (rxSecond)
  );

  spiHost #(
    .fastHalfPeriod (fastHalfPeriod),
    .slowHalfPeriod (slowHalfPeriod)
  ) host (
    .clk  (clk),
    .rst  (rst),
    .bus  (bus.slave),
    .sclk (sclk),
    .mosi (mosi),
    .miso (miso),
    .ssN  (ssN)
  );

endmodule

// ==== src/spiHost.sv ====
`timescale 1ns/100ps

/*
  Register-mapped SPI master, mode 0. Clock divider, 8-bit full-duplex
  shifter, card select and a ready flag behind a two-word register map.
*/

module spiHost #(
  parameter int fastHalfPeriod = 1,
  parameter int slowHalfPeriod = 4
) (
  input  logic   clk,
  input  logic   rst,
  regBusIf.slave bus,
  output logic   sclk,
  output logic   mosi,
  input  logic   miso,
  output logic   ssN
);

  localparam int maxHalf = (slowHalfPeriod > fastHalfPeriod) ? slowHalfPeriod
                                                             : fastHalfPeriod;
  localparam int divW    = $clog2(maxHalf) + 1;

  logic             selectCard;
  logic             fastClk;
  logic             ready;
  logic             busy;
  logic [divW-1:0]  divCnt;
  logic [divW-1:0]  halfLen;
  logic [2:0]       bitCnt;
  logic [7:0]       shiftReg;
  logic             misoBit;
  logic             access;
  logic             startXfer;
  logic             edgeDue;
  sdSpiPkg::regWord wrWord;
  sdSpiPkg::regWord stWord;

  // first cycle of an access, ack follows in the next one
  assign access    = bus.stb && !bus.ack;
  assign startXfer = access && bus.we && (bus.addr == sdSpiPkg::dataAddr);
  assign wrWord    = bus.wdata;
  assign halfLen   = fastClk ? divW'(fastHalfPeriod) : divW'(slowHalfPeriod);
  assign edgeDue   = busy && (divCnt == '0);
  assign ssN       = ~selectCard;
  assign mosi      = shiftReg[7];

  always_comb
  begin
    stWord              = '0;
    stWord.status.ready = ready;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bus.ack    <= 1'b0;
      selectCard <= 1'b0;
      fastClk    <= 1'b0;
    end
    else
    begin
      bus.ack <= access;
      if (access && bus.we && bus.addr == sdSpiPkg::ctrlAddr)
      begin
        selectCard <= wrWord.ctrl.selectCard;
        fastClk    <= wrWord.ctrl.fastClk;
      end
    end
  end

  // read data lands together with ack
  always_ff @(posedge clk)
  begin
    if (access && !bus.we)
      bus.rdata <= (bus.addr == sdSpiPkg::ctrlAddr) ? stWord : {24'h0, shiftReg};
  end

  // divider and bit count, 16 half periods per byte
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy   <= 1'b0;
      ready  <= 1'b1;
      sclk   <= 1'b0;
      divCnt <= '0;
      bitCnt <= '0;
    end
    else if (startXfer)
    begin
      busy   <= 1'b1;
      ready  <= 1'b0;
      divCnt <= halfLen - 1'b1;
      bitCnt <= '0;
    end
    else if (edgeDue)
    begin
      divCnt <= halfLen - 1'b1;
      sclk   <= ~sclk;
      if (sclk)
      begin
        bitCnt <= bitCnt + 1'b1;
        // last falling edge ends the byte
        if (bitCnt == 3'd7)
        begin
          busy  <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
    else if (busy)
      divCnt <= divCnt - 1'b1;
  end

  // sample miso on the rising edge, shift on the falling one
  always_ff @(posedge clk)
  begin
    if (startXfer)
      shiftReg <= bus.wdata[7:0];
    else if (edgeDue && !sclk)
      misoBit <= miso;
    else if (edgeDue && sclk)
      shiftReg <= {shiftReg[6:0], misoBit};
  end

  // master drops stb after ack, so each access gets a single ack
  assert property (@(posedge clk) disable iff (rst) bus.ack |=> !bus.stb);

  // the master must poll ready before loading the next byte
  assert property (@(posedge clk) disable iff (rst) startXfer |-> !busy);

  // sclk parks low between bytes
  assert property (@(posedge clk) disable iff (rst) !busy |-> !sclk);

endmodule
